//--- design/haar_pkg.sv
package haar_pkg;

	// window geometry.
	localparam int WIN_W = 10;
	localparam int WIN_H = 10;
	localparam int WIN_PIXELS = WIN_W * WIN_H;

	// one header word per stage and then 18 words per classifier.
	localparam int WORDS_PER_CLASSIFIER = 18;

	localparam int PIXEL_W = 8;
	localparam int II_W = 16;
	localparam int DB_W = 12;
	localparam int ADDR_W = $clog2(WIN_PIXELS);

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [II_W-1:0] ii_t;
	typedef logic [ADDR_W-1:0] ii_addr_t;    // raster index y*10+x.

	typedef struct packed {
		logic [DB_W-ADDR_W-1:0] pad;
		ii_addr_t addr;
	} corner_word_t;

	// a database word is either a corner index or a signed quantity.
	typedef union packed {
		corner_word_t corner;
		logic signed [DB_W-1:0] value;
	} db_word_u;

	typedef logic signed [31:0] feature_value_t;    // weighted rectangle sum.
	typedef logic signed [15:0] vote_sum_t;

endpackage

//--- design/feature_if.sv
interface feature_if;
	import haar_pkg::*;

	// four corners per rectangle, three rectangles.
	ii_addr_t corner [12];
	logic signed [DB_W-1:0] weight [3];
	logic signed [DB_W-1:0] node_threshold;
	logic signed [DB_W-1:0] left_value;
	logic signed [DB_W-1:0] right_value;
	logic last;     // classifier closes the stage.
	logic start;    // one-cycle pulse from which the fields are valid.

	modport loader (
		output corner, weight, node_threshold, left_value, right_value,
		output last, start
	);

	modport evaluator (
		input corner, weight, node_threshold, left_value, right_value,
		input last, start
	);

endinterface

//--- design/integral_image_buffer.sv
module integral_image_buffer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               pixel_valid,
	input  haar_pkg::pixel_t   pixel,
	output logic               image_ready,
	input  haar_pkg::ii_addr_t rd_addr,
	output haar_pkg::ii_t      rd_data
);
	import haar_pkg::*;

	localparam int XW = $clog2(WIN_W);
	localparam logic [XW-1:0] X_LAST = XW'(WIN_W - 1);
	localparam ii_addr_t ADDR_LAST = ii_addr_t'(WIN_PIXELS - 1);
	localparam ii_addr_t ADDR_ROW1 = ii_addr_t'(WIN_W);

	ii_t mem [WIN_PIXELS];
	ii_t col_sum [WIN_W];    // sum of the column from row 0 down to the current row.
	ii_t row_acc;            // sum of updated column sums left of x.
	ii_t col_new;
	ii_t entry;
	ii_addr_t wr_addr;
	logic [XW-1:0] x_cnt;
	logic first_row;

	// row 0 of a frame ignores the old column sums, which clears them.
	assign first_row = wr_addr < ADDR_ROW1;

	always_comb
	begin
		col_new = (first_row ? '0 : col_sum[x_cnt]) + ii_t'(pixel);
		entry = ((x_cnt == '0) ? '0 : row_acc) + col_new;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_addr <= '0;
			x_cnt <= '0;
			image_ready <= 1'b0;
		end
		else if (pixel_valid)
		begin
			if (wr_addr == ADDR_LAST)
			begin
				wr_addr <= '0;
				image_ready <= 1'b1;    // 100th pixel written.
			end
			else
			begin
				wr_addr <= wr_addr + 1'b1;
				image_ready <= 1'b0;
			end
			x_cnt <= (x_cnt == X_LAST) ? '0 : x_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pixel_valid)
		begin
			mem[wr_addr] <= entry;
			col_sum[x_cnt] <= col_new;
			row_acc <= entry;
		end
		rd_data <= mem[rd_addr];    // one cycle read latency.
	end

endmodule

//--- design/classifier_loader.sv
module classifier_loader #(
	parameter int NUM_CLASSIFIERS = 4
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           word_valid,
	input  haar_pkg::db_word_u             word,
	input  logic                           busy,
	feature_if.loader                      fi,
	output logic signed [haar_pkg::DB_W-1:0] stage_threshold
);
	import haar_pkg::*;

	localparam int CW = (NUM_CLASSIFIERS > 1) ? $clog2(NUM_CLASSIFIERS) : 1;
	localparam logic [CW-1:0] CLS_LAST = CW'(NUM_CLASSIFIERS - 1);
	localparam logic [4:0] WORD_LAST = 5'(WORDS_PER_CLASSIFIER - 1);

	logic accept;
	logic hdr_expected;
	logic [4:0] word_cnt;
	logic [CW-1:0] cls_cnt;
	logic [3:0] corner_idx;

	assign accept = word_valid && !busy;    // words during busy are dropped.

	// corner slots skip the weight word that closes each rectangle.
	always_comb
	begin
		if (word_cnt < 5'd5)
			corner_idx = word_cnt[3:0];
		else if (word_cnt < 5'd10)
			corner_idx = word_cnt[3:0] - 4'd1;
		else
			corner_idx = word_cnt[3:0] - 4'd2;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hdr_expected <= 1'b1;
			word_cnt <= '0;
			cls_cnt <= '0;
			fi.start <= 1'b0;
			fi.last <= 1'b0;
		end
		else
		begin
			fi.start <= 1'b0;
			if (accept)
			begin
				if (hdr_expected)
				begin
					hdr_expected <= 1'b0;
					word_cnt <= '0;
					cls_cnt <= '0;
				end
				else if (word_cnt == WORD_LAST)
				begin
					word_cnt <= '0;
					fi.start <= 1'b1;
					fi.last <= (cls_cnt == CLS_LAST);
					if (cls_cnt == CLS_LAST)
					begin
						hdr_expected <= 1'b1;    // next word opens a new stage.
						cls_cnt <= '0;
					end
					else
						cls_cnt <= cls_cnt + 1'b1;
				end
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && hdr_expected)
			stage_threshold <= word.value;
		if (accept && !hdr_expected)
		begin
			case (word_cnt)
				5'd4:    fi.weight[0] <= word.value;
				5'd9:    fi.weight[1] <= word.value;
				5'd14:   fi.weight[2] <= word.value;
				5'd15:   fi.node_threshold <= word.value;
				5'd16:   fi.left_value <= word.value;
				5'd17:   fi.right_value <= word.value;
				default: fi.corner[corner_idx] <= word.corner.addr;
			endcase
		end
	end

endmodule

//--- design/feature_evaluator.sv
module feature_evaluator (
	input  logic                             clk,
	input  logic                             rst_n,
	feature_if.evaluator                     fi,
	output haar_pkg::ii_addr_t               rd_addr,
	input  haar_pkg::ii_t                    rd_data,
	output logic                             busy,
	output logic                             vote_valid,
	output logic signed [haar_pkg::DB_W-1:0] vote,
	output logic                             vote_last
);
	import haar_pkg::*;

	localparam int NUM_CORNERS = 12;
	localparam int NUM_RECTS = 3;
	localparam logic [3:0] STEP_DONE = 4'(NUM_CORNERS);

	logic running;
	logic [3:0] step;          // next corner to address.
	logic [3:0] addr_idx;
	logic addr_phase;
	logic cap_valid;           // rd_data holds a corner this cycle.
	logic sum_go;
	logic vote_pending;
	ii_t corner_val [NUM_CORNERS];
	logic signed [II_W+1:0] rect_diff [NUM_RECTS];
	feature_value_t weighted_sum;
	feature_value_t feature_value;

	// corner 0 goes out in the start cycle itself.
	assign addr_phase = fi.start || (running && step < STEP_DONE);
	assign addr_idx = (fi.start || step >= STEP_DONE) ? '0 : step;
	assign rd_addr = fi.corner[addr_idx];
	assign busy = fi.start || running;

	// weighted sum of (A+D)-(B+C) over the three rectangles.
	always_comb
	begin
		weighted_sum = '0;
		for (int r = 0; r < NUM_RECTS; r++)
		begin
			rect_diff[r] = $signed({2'b00, corner_val[4*r]})
				+ $signed({2'b00, corner_val[4*r+3]})
				- $signed({2'b00, corner_val[4*r+1]})
				- $signed({2'b00, corner_val[4*r+2]});
			weighted_sum = weighted_sum
				+ feature_value_t'(rect_diff[r]) * feature_value_t'(fi.weight[r]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			step <= STEP_DONE;
			cap_valid <= 1'b0;
			sum_go <= 1'b0;
			vote_pending <= 1'b0;
		end
		else
		begin
			cap_valid <= addr_phase;
			sum_go <= cap_valid && !addr_phase;    // last corner captured.
			vote_pending <= sum_go;
			if (fi.start)
			begin
				running <= 1'b1;
				step <= 4'd1;
			end
			else
			begin
				if (addr_phase)
					step <= step + 1'b1;
				if (vote_pending)
					running <= 1'b0;
			end
		end
	end

	// corners shift in so that corner_val[i] ends up with corner i.
	always_ff @(posedge clk)
	begin
		if (cap_valid)
		begin
			for (int i = 0; i < NUM_CORNERS - 1; i++)
			begin
				corner_val[i] <= corner_val[i+1];
			end
			corner_val[NUM_CORNERS-1] <= rd_data;
		end
		if (sum_go)
			feature_value <= weighted_sum;
	end

	// compare and select in the vote cycle.
	assign vote_valid = vote_pending;
	assign vote = (feature_value > feature_value_t'(fi.node_threshold)) ?
		fi.right_value : fi.left_value;
	assign vote_last = fi.last;

endmodule

//--- design/stage_accumulator.sv
module stage_accumulator (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             vote_valid,
	input  logic signed [haar_pkg::DB_W-1:0] vote,
	input  logic                             vote_last,
	input  logic signed [haar_pkg::DB_W-1:0] stage_threshold,
	output logic                             candidate_valid,
	output logic                             candidate,
	output haar_pkg::vote_sum_t              stage_sum
);
	import haar_pkg::*;

	vote_sum_t acc;      // running sum of the open stage.
	vote_sum_t total;

	assign total = acc + vote_sum_t'(vote);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			acc <= '0;
			candidate_valid <= 1'b0;
			candidate <= 1'b0;
		end
		else
		begin
			candidate_valid <= 1'b0;
			if (vote_valid)
			begin
				if (vote_last)
				begin
					acc <= '0;
					candidate_valid <= 1'b1;
					// equal to the threshold is not a candidate.
					candidate <= total > vote_sum_t'(stage_threshold);
				end
				else
					acc <= total;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (vote_valid && vote_last)
			stage_sum <= total;
	end

endmodule

//--- design/haar_stage_top.sv
module haar_stage_top #(
	parameter int NUM_CLASSIFIERS = 4
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             pixel_valid,
	input  haar_pkg::pixel_t                 pixel,
	output logic                             image_ready,
	input  logic                             word_valid,
	input  logic [haar_pkg::DB_W-1:0]        word,
	output logic                             busy,
	output logic                             vote_valid,
	output logic signed [haar_pkg::DB_W-1:0] vote,
	output logic                             candidate_valid,
	output logic                             candidate,
	output haar_pkg::vote_sum_t              stage_sum
);
	import haar_pkg::*;

	ii_addr_t rd_addr;
	ii_t rd_data;
	logic vote_last;
	logic signed [DB_W-1:0] stage_threshold;

	feature_if fi ();

	integral_image_buffer u_buffer (
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.image_ready (image_ready),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

	classifier_loader #(
		.NUM_CLASSIFIERS (NUM_CLASSIFIERS)
	) u_loader (
		.clk             (clk),
		.rst_n           (rst_n),
		.word_valid      (word_valid),
		.word            (word),
		.busy            (busy),
		.fi              (fi),
		.stage_threshold (stage_threshold)
	);

	feature_evaluator u_evaluator (
		.clk        (clk),
		.rst_n      (rst_n),
		.fi         (fi),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.busy       (busy),
		.vote_valid (vote_valid),
		.vote       (vote),
		.vote_last  (vote_last)
	);

	stage_accumulator u_accumulator (
		.clk             (clk),
		.rst_n           (rst_n),
		.vote_valid      (vote_valid),
		.vote            (vote),
		.vote_last       (vote_last),
		.stage_threshold (stage_threshold),
		.candidate_valid (candidate_valid),
		.candidate       (candidate),
		.stage_sum       (stage_sum)
	);

endmodule

//--- tests/haar_stage_props.sv
module haar_stage_props (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic word_valid,
	input logic vote_valid,
	input logic vote_last,
	input logic candidate_valid
);

	// vote cycle is 14 after start and 15 after the last word.
	a_vote_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##14 vote_valid)
	else $error("vote_valid missing 14 cycles after start");

	a_vote_has_start: assert property (@(posedge clk) disable iff (!rst_n)
		vote_valid |-> $past(start, 14))
	else $error("vote_valid without a start 14 cycles before");

	a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
		busy && !vote_valid |=> busy)
	else $error("busy fell before vote_valid");

	a_candidate_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		vote_valid && vote_last |=> candidate_valid)
	else $error("candidate_valid did not follow the last vote");

	a_candidate_cause: assert property (@(posedge clk) disable iff (!rst_n)
		candidate_valid |-> $past(vote_valid && vote_last))
	else $error("candidate_valid without a last vote");

	a_no_word_busy: assert property (@(posedge clk) disable iff (!rst_n)
		word_valid |-> !busy)
	else $error("database word sent while busy");

endmodule

// evaluator and accumulator signals meet at the top.
bind haar_stage_top haar_stage_props props (
	.clk             (clk),
	.rst_n           (rst_n),
	.start           (fi.start),
	.busy            (busy),
	.word_valid      (word_valid),
	.vote_valid      (vote_valid),
	.vote_last       (vote_last),
	.candidate_valid (candidate_valid)
);

//--- tests/haar_stage_tb.sv
module haar_stage_tb;
	import haar_pkg::*;

	localparam int NUM_CLS = 4;
	localparam int STAGES_PER_FRAME = 6;
	localparam int VOTE_LATENCY = 15;
	// worst case has three idle cycles before every word and then the vote.
	localparam int CLS_CYCLES = WORDS_PER_CLASSIFIER * 4 + VOTE_LATENCY;
	localparam int STAGE_CYCLES = 4 + NUM_CLS * CLS_CYCLES + 1;
	localparam int CYCLE_LIMIT = 4 * ((2 * STAGES_PER_FRAME + 3) * STAGE_CYCLES + 3 * WIN_PIXELS);

	logic clk;
	logic rst_n;
	logic pixel_valid;
	pixel_t pixel;
	logic image_ready;
	logic word_valid;
	logic [DB_W-1:0] word;
	logic busy;
	logic vote_valid;
	logic signed [DB_W-1:0] vote;
	logic candidate_valid;
	logic candidate;
	vote_sum_t stage_sum;

	integer seed;
	int cycle_count;
	int word_cycle;               // cycle in which the latest word was driven.
	int ii_model [WIN_PIXELS];    // integral image of the current frame.
	int cls_corner [NUM_CLS][12];
	int cls_weight [NUM_CLS][3];
	int cls_thr [NUM_CLS];
	int cls_left [NUM_CLS];
	int cls_right [NUM_CLS];
	int cls_vote [NUM_CLS];

	haar_stage_top #(.NUM_CLASSIFIERS(NUM_CLS)) UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the tests did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;    // outputs have settled and inputs change here.
	endtask

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	task automatic check_idle_outputs();
		assert (!busy && !image_ready && !vote_valid && !candidate_valid)
		else report_error("status outputs not low after reset");
	endtask

	task automatic load_frame();
		int pix [WIN_PIXELS];
		int sum;
		for (int i = 0; i < WIN_PIXELS; i++)
			pix[i] = rand_range(0, 255);
		for (int i = 0; i < WIN_PIXELS; i++)
		begin
			sum = 0;    // rows 0..y and columns 0..x.
			for (int j = 0; j < WIN_PIXELS; j++)
				if (j / WIN_W <= i / WIN_W && j % WIN_W <= i % WIN_W)
					sum += pix[j];
			ii_model[i] = sum;
		end
		for (int i = 0; i < WIN_PIXELS; i++)
		begin
			pixel_valid = 1'b1;
			pixel = pixel_t'(pix[i]);
			next_cycle();
			assert (image_ready == (i == WIN_PIXELS - 1))
			else report_error($sformatf("image_ready %0b after pixel %0d", image_ready, i));
		end
		pixel_valid = 1'b0;
	endtask

	function automatic int feature_of(input int c);
		int total;
		int diff;
		total = 0;
		for (int r = 0; r < 3; r++)
		begin
			diff = ii_model[cls_corner[c][4*r]] + ii_model[cls_corner[c][4*r+3]]
				- ii_model[cls_corner[c][4*r+1]] - ii_model[cls_corner[c][4*r+2]];
			total += diff * cls_weight[c][r];
		end
		return total;
	endfunction

	task automatic make_classifiers();
		int fv;
		for (int c = 0; c < NUM_CLS; c++)
		begin
			for (int k = 0; k < 12; k++)
				cls_corner[c][k] = rand_range(0, WIN_PIXELS - 1);
			for (int r = 0; r < 3; r++)
				cls_weight[c][r] = rand_range(-3, 3);
			cls_left[c] = rand_range(-500, 500);
			cls_right[c] = rand_range(-500, 500);
			fv = feature_of(c);
			// half the thresholds sit right next to the feature value.
			if (rand_range(0, 1) == 1)
				cls_thr[c] = fv + rand_range(-1, 1);
			else
				cls_thr[c] = rand_range(-2048, 2047);
			// a node threshold is a 12-bit signed word.
			if (cls_thr[c] > 2047)
				cls_thr[c] = 2047;
			else if (cls_thr[c] < -2048)
				cls_thr[c] = -2048;
			cls_vote[c] = (fv > cls_thr[c]) ? cls_right[c] : cls_left[c];
		end
	endtask

	task automatic send_word(input int value);
		int gap;
		gap = rand_range(0, 3);
		while (busy)
			next_cycle();
		repeat (gap)
			next_cycle();
		word_valid = 1'b1;
		word = DB_W'(value);
		word_cycle = cycle_count;
		next_cycle();
		word_valid = 1'b0;
	endtask

	task automatic run_classifier(input int c);
		for (int r = 0; r < 3; r++)
		begin
			for (int k = 0; k < 4; k++)
				send_word(cls_corner[c][4*r+k]);
			send_word(cls_weight[c][r]);
		end
		send_word(cls_thr[c]);
		send_word(cls_left[c]);
		send_word(cls_right[c]);
		while (!vote_valid)
		begin
			assert (busy)
			else report_error("busy fell before the vote arrived");
			next_cycle();
		end
		assert (cycle_count - word_cycle == VOTE_LATENCY)
		else report_error($sformatf("vote after %0d cycles", cycle_count - word_cycle));
		assert (vote == DB_W'(cls_vote[c]))
		else report_error($sformatf("classifier %0d vote %0d, expected %0d", c, vote, cls_vote[c]));
	endtask

	// mode 0 puts the stage threshold on the sum and mode 1 just below it.
	task automatic run_stage(input int mode, input int n_run);
		int exp_sum;
		int thr;
		make_classifiers();
		exp_sum = 0;
		for (int c = 0; c < NUM_CLS; c++)
			exp_sum += cls_vote[c];
		thr = (mode == 0) ? exp_sum : (mode == 1) ? exp_sum - 1 : rand_range(-2048, 2047);
		send_word(thr);
		for (int c = 0; c < n_run; c++)
			run_classifier(c);
		if (n_run == NUM_CLS)
		begin
			next_cycle();
			assert (candidate_valid)
			else report_error("candidate_valid missing after the last vote");
			assert (stage_sum == vote_sum_t'(exp_sum))
			else report_error($sformatf("stage_sum %0d, expected %0d", stage_sum, exp_sum));
			assert (candidate == (exp_sum > thr))
			else report_error($sformatf("candidate %0b, sum %0d thr %0d", candidate, exp_sum, thr));
		end
	endtask

	initial
	begin
		seed = 32'h900c_593e;
		rst_n = 1'b0;
		pixel_valid = 1'b0;
		pixel = '0;
		word_valid = 1'b0;
		word = '0;
		repeat (10)
			@(posedge clk);
		#1;
		check_idle_outputs();
		rst_n = 1'b1;
		load_frame();
		for (int s = 0; s < STAGES_PER_FRAME; s++)
			run_stage(s % 3, NUM_CLS);
		load_frame();    // votes now follow the second frame only.
		for (int s = 0; s < STAGES_PER_FRAME; s++)
			run_stage(s % 3, NUM_CLS);
		run_stage(2, NUM_CLS / 2);
		rst_n = 1'b0;    // partial stage is dropped.
		repeat (10)
			next_cycle();
		check_idle_outputs();
		rst_n = 1'b1;
		load_frame();
		run_stage(0, NUM_CLS);
		run_stage(1, NUM_CLS);
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- sources.f
design/haar_pkg.sv
design/feature_if.sv
design/integral_image_buffer.sv
design/classifier_loader.sv
design/feature_evaluator.sv
design/stage_accumulator.sv
design/haar_stage_top.sv
tests/haar_stage_props.sv
tests/haar_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module haar_stage_tb -f sources.f -o haar_stage_sim \
	&& ./obj_dir/haar_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
[ -f sim.log ] && ! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
	&& echo "PASS" && exit 0
echo "FAIL" && exit 1
